// ==== arith_pkg.sv ====
package arith_pkg;

  // operand and slice widths
  localparam int DATA_W  = 8;
  localparam int SLICE_W = 4;

  // operation select
  localparam int OP_W = 2;

  localparam logic [OP_W-1:0] OP_ADD = 2'd0;
  localparam logic [OP_W-1:0] OP_SUB = 2'd1;
  localparam logic [OP_W-1:0] OP_CMP = 2'd2;
  // code 3 is reserved and yields an all-zero result

  // result word, one bit above the data for carry or borrow
  localparam int RESULT_W = DATA_W + 1;

  // one result register, two readings of it
  // arith view for add and subtract
  // cmp view for magnitude compare
  typedef union packed {
    struct packed {
      // carry for add, borrow for subtract
      logic              carry;
      logic [DATA_W-1:0] data;
    } arith;
    struct packed {
      // always zero in compare results
      logic [RESULT_W-3:0] pad;
      logic                eq;
      logic                gt;
    } cmp;
  } result_u;

endpackage

// ==== ripple_adder.sv ====
`timescale 1ns/1ps

module ripple_adder #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input  logic [WIDTH-1:0] i_a,
  input  logic [WIDTH-1:0] i_b,
  output logic [WIDTH-1:0] o_sum,
  output logic             o_carry
);

  // carry out of each bit position
  logic [WIDTH-1:0] carry;

  // bit 0 has no carry in, so a half adder is enough
  assign o_sum[0] = i_a[0] ^ i_b[0];
  assign carry[0] = i_a[0] & i_b[0];

  // full adder cells, each fed by the carry from the bit below
  for (genvar i = 1; i < WIDTH; i++) begin : g_fa
    logic a_bit;
    logic b_bit;
    logic c_in;

    assign a_bit = i_a[i];
    assign b_bit = i_b[i];
    assign c_in  = carry[i-1];

    // sum is the parity of all three inputs
    assign o_sum[i] = a_bit ^ b_bit ^ c_in;

    // carry out is the majority of the three
    assign carry[i] = (a_bit & b_bit) | (b_bit & c_in) | (a_bit & c_in);
  end

  // carry from the top cell leaves the chain
  assign o_carry = carry[WIDTH-1];

endmodule

// ==== ripple_subtractor.sv ====
`timescale 1ns/1ps

module ripple_subtractor #(
  parameter int WIDTH = arith_pkg::DATA_W
) (
  input  logic [WIDTH-1:0] i_a,
  input  logic [WIDTH-1:0] i_b,
  output logic [WIDTH-1:0] o_diff,
  output logic             o_borrow
);

  // borrow out of each bit position
  logic [WIDTH-1:0] borrow;

  // half subtractor at bit 0
  // borrow only when a is 0 and b is 1
  assign o_diff[0] = i_a[0] ^ i_b[0];
  assign borrow[0] = ~i_a[0] & i_b[0];

  // modified full subtractor cells
  // bit inequality is formed once and shared by diff and borrow
  for (genvar i = 1; i < WIDTH; i++) begin : g_fs
    logic a_bit;
    logic b_bit;
    logic b_in;
    logic bits_ne;
    logic own_borrow;
    logic pass_borrow;

    assign a_bit = i_a[i];
    assign b_bit = i_b[i];
    assign b_in  = borrow[i-1];

    // a and b differ at this position
    assign bits_ne = a_bit ^ b_bit;

    assign o_diff[i] = bits_ne ^ b_in;

    // this bit needs a borrow on its own
    assign own_borrow = ~a_bit & b_bit;

    // equal bits pass an incoming borrow straight up
    assign pass_borrow = ~bits_ne & b_in;

    assign borrow[i] = own_borrow | pass_borrow;
  end

  // set exactly when a < b, unsigned
  assign o_borrow = borrow[WIDTH-1];

endmodule

// ==== comparator_slice.sv ====
`timescale 1ns/1ps

module comparator_slice (
  input  logic [arith_pkg::SLICE_W-1:0] i_a,
  input  logic [arith_pkg::SLICE_W-1:0] i_b,
  output logic                          o_eq,
  output logic                          o_gt
);

  import arith_pkg::*;

  // per-bit equality
  logic [SLICE_W-1:0] bit_eq;

  // a bit set where b bit is clear
  logic [SLICE_W-1:0] bit_gt;

  // lookahead terms, one per bit position, msb first
  logic [SLICE_W-1:0] gt_term;

  assign bit_eq = ~(i_a ^ i_b);
  assign bit_gt = i_a & ~i_b;

  // all four bits match
  assign o_eq = &bit_eq;

  // msb decides on its own
  assign gt_term[3] = bit_gt[3];

  // lower bits only count when every bit above them is equal
  assign gt_term[2] = bit_eq[3] & bit_gt[2];

  assign gt_term[1] = bit_eq[3] & bit_eq[2] & bit_gt[1];

  assign gt_term[0] = bit_eq[3] & bit_eq[2] & bit_eq[1] & bit_gt[0];

  // at most one term can be set, so a plain OR
  assign o_gt = |gt_term;

endmodule

// ==== magnitude_comparator.sv ====
`timescale 1ns/1ps

module magnitude_comparator (
  input  logic [arith_pkg::DATA_W-1:0] i_a,
  input  logic [arith_pkg::DATA_W-1:0] i_b,
  output logic                         o_eq,
  output logic                         o_gt
);

  import arith_pkg::*;

  logic hi_eq;
  logic hi_gt;
  logic lo_eq;
  logic lo_gt;

  // upper nibble
  comparator_slice i_cmp_hi (
    .i_a  (i_a[DATA_W-1:SLICE_W]),
    .i_b  (i_b[DATA_W-1:SLICE_W]),
    .o_eq (hi_eq),
    .o_gt (hi_gt)
  );

  // lower nibble
  comparator_slice i_cmp_lo (
    .i_a  (i_a[SLICE_W-1:0]),
    .i_b  (i_b[SLICE_W-1:0]),
    .o_eq (lo_eq),
    .o_gt (lo_gt)
  );

  assign o_eq = hi_eq & lo_eq;

  // high slice decides first, low slice breaks a tie
  assign o_gt = hi_gt | (hi_eq & lo_gt);

endmodule

// ==== arith_unit.sv ====
`timescale 1ns/1ps

module arith_unit (
  input  logic                         RESET,
  input  logic                         i_reset,
  input  logic                         i_valid,
  input  logic [arith_pkg::OP_W-1:0]   i_op,
  input  logic [arith_pkg::DATA_W-1:0] i_a,
  input  logic [arith_pkg::DATA_W-1:0] i_b,
  output logic                         o_valid,
  output arith_pkg::result_u           o_result
);

  import arith_pkg::*;

  // stage 1, captured request
  logic              s1_valid;
  logic [OP_W-1:0]   s1_op;
  logic [DATA_W-1:0] s1_a;
  logic [DATA_W-1:0] s1_b;

  // datapath outputs, all from the stage 1 operands
  logic [DATA_W-1:0] add_sum;
  logic              add_carry;
  logic [DATA_W-1:0] sub_diff;
  logic              sub_borrow;
  logic              cmp_eq;
  logic              cmp_gt;

  // selected result, ahead of the output register
  result_u           res_next;

  // control flag under reset
  always_ff @(posedge RESET) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= i_valid;
    end
  end

  // op and operands only load on a request
  always_ff @(posedge RESET) begin
    if (i_valid) begin
      s1_op <= i_op;
      s1_a  <= i_a;
      s1_b  <= i_b;
    end
  end

  ripple_adder #(
    .WIDTH (DATA_W)
  ) i_adder (
    .i_a     (s1_a),
    .i_b     (s1_b),
    .o_sum   (add_sum),
    .o_carry (add_carry)
  );

  ripple_subtractor #(
    .WIDTH (DATA_W)
  ) i_subtractor (
    .i_a      (s1_a),
    .i_b      (s1_b),
    .o_diff   (sub_diff),
    .o_borrow (sub_borrow)
  );

  magnitude_comparator i_comparator (
    .i_a  (s1_a),
    .i_b  (s1_b),
    .o_eq (cmp_eq),
    .o_gt (cmp_gt)
  );

  // pick the view that matches the op
  // reserved code falls through as all zero
  always_comb begin
    res_next = '0;
    case (s1_op)
      OP_ADD: begin
        res_next.arith.carry = add_carry;
        res_next.arith.data  = add_sum;
      end
      OP_SUB: begin
        res_next.arith.carry = sub_borrow;
        res_next.arith.data  = sub_diff;
      end
      OP_CMP: begin
        res_next.cmp.eq = cmp_eq;
        res_next.cmp.gt = cmp_gt;
      end
      default: begin
        res_next = '0;
      end
    endcase
  end

  // stage 2, result shown for a single cycle
  always_ff @(posedge RESET) begin
    if (i_reset) begin
      o_valid  <= 1'b0;
      o_result <= '0;
    end else begin
      o_valid  <= s1_valid;
      o_result <= res_next;
    end
  end

endmodule

// ==== arith_unit_assert.sv ====
`timescale 1ns/1ps

module arith_unit_assert (
  input logic                       RESET,
  input logic                       i_reset,
  input logic                       i_valid,
  input logic                       i_out_valid,
  input arith_pkg::result_u         i_result,
  input logic [arith_pkg::OP_W-1:0] i_s1_op
);

  import arith_pkg::*;

  // quiet output while reset is held and on the edge after it
  a_reset_quiet: assert property (@(posedge RESET) i_reset |=> !i_out_valid)
    else $error("o_valid high during or right after reset");

  // two register stages between request and result
  a_latency: assert property (@(posedge RESET) disable iff (i_reset)
    i_out_valid == $past(i_valid, 2))
    else $error("o_valid does not follow i_valid by two cycles");

  // compare results carry no stray bits
  a_cmp_pad: assert property (@(posedge RESET) disable iff (i_reset)
    (i_out_valid && $past(i_s1_op) == OP_CMP) |-> (i_result.cmp.pad == '0))
    else $error("compare result has nonzero pad bits");

  // a cannot be both equal to and greater than b
  a_cmp_excl: assert property (@(posedge RESET) disable iff (i_reset)
    (i_out_valid && $past(i_s1_op) == OP_CMP) |-> !(i_result.cmp.eq && i_result.cmp.gt))
    else $error("compare result has eq and gt both set");

endmodule

// ==== arith_unit_tb.sv ====
`timescale 1ns/1ps

module arith_unit_tb;

  import arith_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 10;
  localparam int DRAIN_CYCLES = 5;
  localparam int N_ADD        = 200;
  localparam int N_SUB        = 200;
  localparam int N_CMP        = 200;
  localparam int N_MIX        = 100;
  localparam int TOTAL_REQ    = N_ADD + N_SUB + N_CMP + N_MIX;
  localparam logic [31:0] SEED = 32'h225da580;

  // one request per cycle, plus reset, idle and the drain after each test
  localparam int RUN_CYCLES  = TOTAL_REQ + RESET_CYCLES + IDLE_CYCLES + 4 * (DRAIN_CYCLES + 1);
  localparam int WATCHDOG_NS = (RUN_CYCLES + 20) * CLK_PERIOD;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [OP_W-1:0]   op_t;

  localparam op_t OP_RSVD = 2'd3;

  // request in flight and the result it should give
  typedef struct packed {
    op_t     op;
    data_t   a;
    data_t   b;
    result_u res;
  } req_t;

  logic    RESET;
  logic    reset;
  logic    valid;
  op_t     op;
  data_t   a;
  data_t   b;
  logic    out_valid;
  result_u result;

  int   checks = 0;
  int   errors = 0;
  int   results = 0;
  int   test_errors0 = 0;
  int   test_results0 = 0;
  req_t exp_q[$];

  arith_unit i_arith_unit (
    .RESET    (RESET),
    .i_reset  (reset),
    .i_valid  (valid),
    .i_op     (op),
    .i_a      (a),
    .i_b      (b),
    .o_valid  (out_valid),
    .o_result (result)
  );

  bind arith_unit arith_unit_assert i_assert (
    .RESET       (RESET),
    .i_reset     (i_reset),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_result    (o_result),
    .i_s1_op     (s1_op)
  );

  initial begin
    RESET = 1'b0;
    forever #(CLK_PERIOD / 2) RESET = ~RESET;
  end

  // expected result from plain integer arithmetic
  function automatic result_u model(input op_t op_in, input data_t a_in, input data_t b_in);
    result_u r;
    int ai;
    int bi;
    int sum;
    ai = int'(a_in);
    bi = int'(b_in);
    r = '0;
    case (op_in)
      OP_ADD: begin
        sum = ai + bi;
        r.arith.carry = (sum >= 2 ** DATA_W);
        r.arith.data  = data_t'(sum % (2 ** DATA_W));
      end
      OP_SUB: begin
        r.arith.carry = (ai < bi);
        r.arith.data  = data_t'((ai - bi + 2 ** DATA_W) % (2 ** DATA_W));
      end
      OP_CMP: begin
        r.cmp.eq = (ai == bi);
        r.cmp.gt = (ai > bi);
      end
      default: begin
        r = '0;
      end
    endcase
    return r;
  endfunction

  task automatic check_arith(input result_u got, input result_u exp_res, input string what);
    checks++;
    if (got.arith !== exp_res.arith) begin
      errors++;
      $display("FAILED at %0t: %s, got carry %0b data 0x%02h, expected carry %0b data 0x%02h",
               $time, what, got.arith.carry, got.arith.data,
               exp_res.arith.carry, exp_res.arith.data);
    end
  endtask

  task automatic check_cmp(input result_u got, input result_u exp_res, input string what);
    checks++;
    if (got.cmp !== exp_res.cmp) begin
      errors++;
      $display("FAILED at %0t: %s, got pad 0x%0h eq %0b gt %0b, expected pad 0x%0h eq %0b gt %0b",
               $time, what, got.cmp.pad, got.cmp.eq, got.cmp.gt,
               exp_res.cmp.pad, exp_res.cmp.eq, exp_res.cmp.gt);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp_v, input string what);
    checks++;
    if (got !== exp_v) begin
      errors++;
      $display("FAILED at %0t: %s, got %0b, expected %0b", $time, what, got, exp_v);
    end
  endtask

  // drive one request on the falling edge and queue its expected result
  task automatic send(input op_t op_in, input data_t a_in, input data_t b_in);
    req_t r;
    @(negedge RESET);
    valid = 1'b1;
    op    = op_in;
    a     = a_in;
    b     = b_in;
    r.op  = op_in;
    r.a   = a_in;
    r.b   = b_in;
    r.res = model(op_in, a_in, b_in);
    exp_q.push_back(r);
  endtask

  task automatic start_test();
    test_errors0  = errors;
    test_results0 = results;
  endtask

  task automatic finish_test(input string name, input int n_req);
    int waited;
    int got;
    waited = 0;
    @(negedge RESET);
    valid = 1'b0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(negedge RESET);
      waited++;
    end
    got = results - test_results0;
    if (got != n_req || exp_q.size() != 0) begin
      errors++;
      $display("test %s: sent %0d requests but received %0d results", name, n_req, got);
      exp_q.delete();
    end
    $display("test %s: %0d requests, %0d results, %0d errors",
             name, n_req, got, errors - test_errors0);
  endtask

  // results are stable between rising edges, so look at them on the falling edge
  always @(negedge RESET) begin : result_monitor
    req_t  expected;
    string what;
    if (out_valid === 1'b1) begin
      results++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("a result arrived at %0t with no request outstanding", $time);
      end else begin
        expected = exp_q.pop_front();
        what = $sformatf("op %0d a 0x%02h b 0x%02h", expected.op, expected.a, expected.b);
        if (expected.op == OP_CMP) begin
          check_cmp(result, expected.res, what);
        end else begin
          check_arith(result, expected.res, what);
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    data_t ra;
    data_t rb;
    op_t   rop;
    int    kind;

    reset = 1'b1;
    valid = 1'b0;
    op    = '0;
    a     = '0;
    b     = '0;
    void'($urandom(SEED));

    // reset, then idle with no requests
    start_test();
    repeat (RESET_CYCLES) @(posedge RESET);
    @(negedge RESET);
    check_valid(out_valid, 1'b0, "o_valid in reset");
    check_arith(result, '0, "o_result in reset");
    reset = 1'b0;
    repeat (IDLE_CYCLES) begin
      @(negedge RESET);
      check_valid(out_valid, 1'b0, "o_valid while idle");
    end
    $display("test reset: %0d idle cycles, %0d errors", IDLE_CYCLES, errors - test_errors0);

    start_test();
    for (int i = 0; i < N_ADD; i++) begin
      send(OP_ADD, data_t'($urandom()), data_t'($urandom()));
    end
    finish_test("add", N_ADD);

    start_test();
    for (int i = 0; i < N_SUB; i++) begin
      send(OP_SUB, data_t'($urandom()), data_t'($urandom()));
    end
    finish_test("subtract", N_SUB);

    // equal pairs and high nibble ties mixed with plain random pairs
    start_test();
    for (int i = 0; i < N_CMP; i++) begin
      ra = data_t'($urandom());
      kind = $urandom_range(0, 3);
      case (kind)
        0: rb = ra;
        1: rb = {ra[DATA_W-1:SLICE_W], SLICE_W'($urandom())};
        default: rb = data_t'($urandom());
      endcase
      send(OP_CMP, ra, rb);
    end
    finish_test("compare", N_CMP);

    // back to back, reserved code forced now and then
    start_test();
    for (int i = 0; i < N_MIX; i++) begin
      if (i % 7 == 3) begin
        rop = OP_RSVD;
      end else begin
        rop = op_t'($urandom_range(0, 3));
      end
      send(rop, data_t'($urandom()), data_t'($urandom()));
    end
    finish_test("mix", N_MIX);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== arith_unit.f ====
arith_pkg.sv
ripple_adder.sv
ripple_subtractor.sv
comparator_slice.sv
magnitude_comparator.sv
arith_unit.sv
arith_unit_assert.sv
arith_unit_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := arith_unit_tb
FILELIST  := arith_unit.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED: run ended early"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
